/* all.f */
convPkg.sv
lMac.sv
lShl.sv
scratchRam.sv
convolve.sv
convTop.sv
convTb.sv

/* convPkg.sv */
package convPkg;

	//////////////////////////////
	// Widths

	localparam int SAMPLE_W   = 16;
	localparam int ACC_W      = 32;
	localparam int WORD_W     = 32;
	localparam int MEM_ADDR_W = 11;
	// Each region is 64 words, so the base is the top five address bits
	localparam int REGION_W   = 6;
	localparam int BASE_W     = MEM_ADDR_W - REGION_W;

	//////////////////////////////
	// Algorithm constants

	// Vector length L
	localparam int VECTOR_LEN = 40;
	localparam int SHL_AMOUNT = 3;
	localparam int SHL_CNT_W  = $clog2(SHL_AMOUNT + 1);
	localparam int MEM_DEPTH  = 2048;

	localparam logic signed [ACC_W-1:0] ACC_MAX     = 32'sh7FFF_FFFF;
	localparam logic signed [ACC_W-1:0] ACC_MIN     = 32'sh8000_0000;
	// Raw product of -32768 * -32768, the one case where doubling overflows
	localparam logic signed [ACC_W-1:0] L_MULT_OVF  = 32'sh4000_0000;

	//////////////////////////////
	// Types

	typedef logic signed [SAMPLE_W-1:0] sampleT;
	typedef logic signed [ACC_W-1:0]    accT;
	typedef logic [MEM_ADDR_W-1:0]      memAddrT;
	typedef logic [WORD_W-1:0]          memWordT;
	typedef logic [BASE_W-1:0]          baseT;
	typedef logic [REGION_W-1:0]        idxT;

	typedef struct packed {
		memAddrT addr;
		logic    writeEn;
		memWordT data;
	} memReqT;

	typedef struct packed {
		sampleT a;
		sampleT b;
		accT    acc;
	} macReqT;

	typedef struct packed {
		memAddrT addr;
		logic    writeEn;
		memWordT data;
	} hostReqT;

endpackage

/* convTb.sv */
module convTb;
	timeunit 1ns;
	timeprecision 1ps;

	import convPkg::*;

	typedef enum int {patImpulse, patConst, patRandom, patExtreme} patT;

	typedef struct {
		string  name;
		patT    xPat;
		sampleT xVal;
		patT    hPat;
		sampleT hVal;
		baseT   xb;
		baseT   hb;
		baseT   yb;
	} caseT;

	localparam int NUM_CASES = 6;
	// Worst-case sequencer cycles for one run, then load, start and readback
	localparam int RUN_CYCLES = VECTOR_LEN * (SHL_AMOUNT + 4)
		+ 3 * VECTOR_LEN * (VECTOR_LEN + 1) / 2 + 2;
	localparam int IO_CYCLES = 4 * VECTOR_LEN + 12;
	localparam int CYCLE_LIMIT = 2 * (NUM_CASES * (RUN_CYCLES + IO_CYCLES) + 10);

	logic clk = 1'b0;
	logic reset;
	logic start;
	baseT xBase;
	baseT hBase;
	baseT yBase;
	hostReqT host;
	memWordT hostReadData;
	logic done;

	caseT cases [NUM_CASES];
	sampleT xVec [VECTOR_LEN];
	sampleT hVec [VECTOR_LEN];
	int sampleErrors = 0;
	int wordErrors = 0;
	int otherErrors = 0;
	int doneCount = 0;
	int cycleCount = 0;

	convTop convTop_inst
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.xBase(xBase),
		.hBase(hBase),
		.yBase(yBase),
		.host(host),
		.hostReadData(hostReadData),
		.done(done)
	);

	always #20 clk = ~clk;

	always @(negedge clk)
	begin
		if (done === 1'b1)
			doneCount++;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// Reference model

	function automatic longint clampAcc(input longint v);
		if (v > 64'sd2147483647)
			return 64'sd2147483647;
		if (v < -64'sd2147483648)
			return -64'sd2147483648;
		return v;
	endfunction

	// Saturating 2ab, saturating sum, then three saturating doublings
	function automatic sampleT refOutput(input int n);
		longint acc;
		accT word;
		acc = 0;
		for (int k = 0; k <= n; k++)
			acc = clampAcc(acc + clampAcc(2 * longint'(xVec[k]) * longint'(hVec[n - k])));
		for (int k = 0; k < SHL_AMOUNT; k++)
			acc = clampAcc(acc * 2);
		word = accT'(acc);
		return word[31:16];
	endfunction

	function automatic sampleT patValue(input patT kind, input sampleT val, input int idx);
		case (kind)
			patImpulse: return (idx == 0) ? val : sampleT'(0);
			patConst:   return val;
			patExtreme: return sampleT'(16'sh8000);
			default:    return sampleT'($urandom);
		endcase
	endfunction

	// Guard words carry the whole address
	function automatic memWordT guardPattern(input memAddrT addr);
		return {~addr, addr, 10'h2A5};
	endfunction

	//////////////////////////////
	// Host port and compare tasks

	task automatic hostWrite(input memAddrT addr, input memWordT data);
		@(negedge clk);
		host.addr = addr;
		host.writeEn = 1'b1;
		host.data = data;
	endtask

	task automatic hostRead(input memAddrT addr, output memWordT data);
		@(negedge clk);
		host.addr = addr;
		host.writeEn = 1'b0;
		host.data = '0;
		@(negedge clk);
		data = hostReadData;
	endtask

	task automatic checkSample(input string name, input int idx, input sampleT expected,
		input sampleT actual);
		if (actual !== expected)
		begin
			sampleErrors++;
			$display("[ERROR] %s y[%0d]: expected %h, actual %h", name, idx, expected, actual);
		end
	endtask

	task automatic checkWord(input string name, input string what, input memWordT expected,
		input memWordT actual);
		if (actual !== expected)
		begin
			wordErrors++;
			$display("[ERROR] %s %s: expected %h, actual %h", name, what, expected, actual);
		end
	endtask

	//////////////////////////////
	// Case table and main sequence

	initial
	begin
		int startCount;
		memWordT word;
		memAddrT guards [3];

		void'($urandom(78));
		startCount = 0;
		cases = '{
			'{"impulseH", patRandom, 16'sh0, patImpulse, 16'sh7FFF, 5'd1, 5'd2, 5'd3},
			'{"randomXH", patRandom, 16'sh0, patRandom, 16'sh0, 5'd4, 5'd5, 5'd6},
			'{"bothMin", patExtreme, 16'sh0, patExtreme, 16'sh0, 5'd7, 5'd8, 5'd9},
			'{"negOverflow", patExtreme, 16'sh0, patConst, 16'sh7FFF, 5'd10, 5'd11, 5'd12},
			'{"backToBackA", patRandom, 16'sh0, patRandom, 16'sh0, 5'd13, 5'd14, 5'd15},
			'{"backToBackB", patConst, -16'sh1234, patRandom, 16'sh0, 5'd20, 5'd21, 5'd22}
		};

		reset = 1'b1;
		start = 1'b0;
		xBase = '0;
		hBase = '0;
		yBase = '0;
		host = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		for (int c = 0; c < NUM_CASES; c++)
		begin
			xBase = cases[c].xb;
			hBase = cases[c].hb;
			yBase = cases[c].yb;
			guards[0] = {cases[c].xb, idxT'(VECTOR_LEN)};
			guards[1] = {cases[c].hb, idxT'(VECTOR_LEN)};
			guards[2] = {cases[c].yb, idxT'(VECTOR_LEN)};
			for (int k = 0; k < VECTOR_LEN; k++)
			begin
				xVec[k] = patValue(cases[c].xPat, cases[c].xVal, k);
				hVec[k] = patValue(cases[c].hPat, cases[c].hVal, k);
				hostWrite({cases[c].xb, idxT'(k)}, {16'h0000, xVec[k]});
				hostWrite({cases[c].hb, idxT'(k)}, {16'h0000, hVec[k]});
			end
			foreach (guards[g])
				hostWrite(guards[g], guardPattern(guards[g]));

			@(negedge clk);
			host.writeEn = 1'b0;
			start = 1'b1;
			startCount++;
			@(negedge clk);
			start = 1'b0;
			while (done !== 1'b1)
				@(negedge clk);

			for (int k = 0; k < VECTOR_LEN; k++)
			begin
				hostRead({cases[c].yb, idxT'(k)}, word);
				checkSample(cases[c].name, k, refOutput(k), word[15:0]);
				checkWord(cases[c].name, "upper half of y", '0, word >> 16);
			end
			foreach (guards[g])
			begin
				hostRead(guards[g], word);
				checkWord(cases[c].name, "guard word", guardPattern(guards[g]), word);
			end
			if (doneCount != startCount)
			begin
				otherErrors++;
				$display("Case %s: saw %0d done pulses after %0d starts",
					cases[c].name, doneCount, startCount);
			end
		end

		$display("Errors: sample %0d, word %0d, other %0d", sampleErrors, wordErrors, otherErrors);
		if (sampleErrors + wordErrors + otherErrors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* convTop.sv */
module convTop
	(
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  convPkg::baseT    xBase,
	input  convPkg::baseT    hBase,
	input  convPkg::baseT    yBase,
	input  convPkg::hostReqT host,
	output convPkg::memWordT hostReadData,
	output logic             done
	);
	import convPkg::*;

	// Engine port of the scratch memory
	memReqT engineReq;
	memWordT engineReadData;

	// Operator links
	macReqT macReq;
	accT macResult;
	logic shlStart;
	accT shlValue;
	logic shlDone;
	accT shlResult;

	convolve convolve_inst
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.xBase(xBase),
		.hBase(hBase),
		.yBase(yBase),
		.engineReq(engineReq),
		.engineReadData(engineReadData),
		.macReq(macReq),
		.macResult(macResult),
		.shlStart(shlStart),
		.shlValue(shlValue),
		.shlDone(shlDone),
		.shlResult(shlResult),
		.done(done)
	);

	lMac lMac_inst
	(
		.macReq(macReq),
		.macResult(macResult)
	);

	lShl lShl_inst
	(
		.clk(clk),
		.reset(reset),
		.shlStart(shlStart),
		.shlValue(shlValue),
		.shlDone(shlDone),
		.shlResult(shlResult)
	);

	scratchRam scratchRam_inst
	(
		.clk(clk),
		.engineReq(engineReq),
		.engineReadData(engineReadData),
		.host(host),
		.hostReadData(hostReadData)
	);

endmodule

/* convolve.sv */
module convolve
	(
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  convPkg::baseT    xBase,
	input  convPkg::baseT    hBase,
	input  convPkg::baseT    yBase,
	output convPkg::memReqT  engineReq,
	input  convPkg::memWordT engineReadData,
	output convPkg::macReqT  macReq,
	input  convPkg::accT     macResult,
	output logic             shlStart,
	output convPkg::accT     shlValue,
	input  logic             shlDone,
	input  convPkg::accT     shlResult,
	output logic             done
	);
	import convPkg::*;

	typedef enum logic [2:0] {
		stateIdle,
		stateOuter,
		stateInner,
		stateReadH,
		stateMac,
		stateShift,
		stateWait
	} stateT;

	stateT state;
	stateT nextState;

	// Outer index n and inner index i
	idxT n;
	idxT i;
	idxT nextN;
	idxT nextI;

	// Running sum and the x sample of the current tap
	accT s;
	sampleT xSample;
	logic clearSum;
	logic loadSum;
	logic loadX;

	//////////////////////////////
	// Control registers

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stateIdle;
			n <= '0;
			i <= '0;
		end
		else
		begin
			state <= nextState;
			n <= nextN;
			i <= nextI;
		end
	end

	//////////////////////////////
	// Datapath registers

	always_ff @(posedge clk)
	begin
		if (clearSum)
			s <= '0;
		else if (loadSum)
			s <= macResult;
		if (loadX)
			xSample <= engineReadData[SAMPLE_W-1:0];
	end

	// Operands only matter in stateMac, where h arrives from memory
	assign macReq.a = engineReadData[SAMPLE_W-1:0];
	assign macReq.b = xSample;
	assign macReq.acc = s;

	assign shlValue = s;

	//////////////////////////////
	// Sequencer

	always_comb
	begin
		nextState = state;
		nextN = n;
		nextI = i;
		clearSum = 1'b0;
		loadSum = 1'b0;
		loadX = 1'b0;
		engineReq = '0;
		shlStart = 1'b0;
		done = 1'b0;

		case (state)
			stateIdle:
			begin
				nextN = '0;
				nextI = '0;
				if (start)
					nextState = stateOuter;
			end

			stateOuter:
			begin
				if (n == idxT'(VECTOR_LEN))
				begin
					done = 1'b1;
					nextState = stateIdle;
				end
				else
				begin
					clearSum = 1'b1;
					nextI = '0;
					nextState = stateInner;
				end
			end

			// Loop test, and the read of x[i] when another tap is left
			stateInner:
			begin
				if (i > n)
					nextState = stateShift;
				else
				begin
					engineReq.addr = {xBase, i};
					nextState = stateReadH;
				end
			end

			stateReadH:
			begin
				loadX = 1'b1;
				engineReq.addr = {hBase, idxT'(n - i)};
				nextState = stateMac;
			end

			stateMac:
			begin
				loadSum = 1'b1;
				nextI = i + 1'b1;
				nextState = stateInner;
			end

			stateShift:
			begin
				shlStart = 1'b1;
				nextState = stateWait;
			end

			// y[n] takes the upper half of the shifted sum
			stateWait:
			begin
				if (shlDone)
				begin
					engineReq.addr = {yBase, n};
					engineReq.writeEn = 1'b1;
					engineReq.data = {{(WORD_W - SAMPLE_W){1'b0}}, shlResult[ACC_W-1 -: SAMPLE_W]};
					nextN = n + 1'b1;
					nextState = stateOuter;
				end
			end

			default:
			begin
				nextState = stateIdle;
			end
		endcase
	end

	//////////////////////////////
	// Checks

	innerBound: assert property (@(posedge clk) disable iff (reset)
		i <= n + 1'b1)
		else $error("convolve: inner index %0d past outer index %0d", i, n);

	doneNoWrite: assert property (@(posedge clk) disable iff (reset)
		done |-> !engineReq.writeEn)
		else $error("convolve: done pulsed together with a y write");

	// Every shift issued must be answered before the next tap starts
	shiftAnswered: assert property (@(posedge clk) disable iff (reset)
		shlStart |-> ##(SHL_AMOUNT + 1) (shlDone && engineReq.writeEn))
		else $error("convolve: shift result missing at the expected cycle");

endmodule

/* lMac.sv */
module lMac
	(
	input  convPkg::macReqT macReq,
	output convPkg::accT    macResult
	);
	import convPkg::*;

	sampleT opA;
	sampleT opB;
	accT rawProduct;
	accT product;
	logic signed [ACC_W:0] wideSum;

	assign opA = macReq.a;
	assign opB = macReq.b;

	// Q15 times Q15 gives Q30, doubled to Q31
	assign rawProduct = opA * opB;

	always_comb
	begin
		if (rawProduct == L_MULT_OVF)
			product = ACC_MAX;
		else
			product = rawProduct <<< 1;
	end

	// One guard bit is enough to see a 32-bit add overflow
	assign wideSum = {macReq.acc[ACC_W-1], macReq.acc} + {product[ACC_W-1], product};

	always_comb
	begin
		if (wideSum[ACC_W] != wideSum[ACC_W-1])
		begin
			// Guard bit holds the true sign
			if (wideSum[ACC_W])
				macResult = ACC_MIN;
			else
				macResult = ACC_MAX;
		end
		else
		begin
			macResult = wideSum[ACC_W-1:0];
		end
	end

endmodule

/* lShl.sv */
module lShl
	(
	input  logic         clk,
	input  logic         reset,
	input  logic         shlStart,
	input  convPkg::accT shlValue,
	output logic         shlDone,
	output convPkg::accT shlResult
	);
	import convPkg::*;

	accT operand;
	logic busy;
	logic [SHL_CNT_W-1:0] stepsLeft;

	// Doubling overflows when the top two bits differ
	function automatic accT shiftOne(input accT value);
		if (value[ACC_W-1] != value[ACC_W-2])
			return value[ACC_W-1] ? ACC_MIN : ACC_MAX;
		return value <<< 1;
	endfunction

	//////////////////////////////
	// Step control

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			stepsLeft <= '0;
		end
		else if (shlStart)
		begin
			busy <= 1'b1;
			stepsLeft <= SHL_CNT_W'(SHL_AMOUNT);
		end
		else if (busy)
		begin
			if (stepsLeft == '0)
				busy <= 1'b0;
			else
				stepsLeft <= stepsLeft - 1'b1;
		end
	end

	// Saturated values map onto themselves under shiftOne
	always_ff @(posedge clk)
	begin
		if (shlStart)
			operand <= shlValue;
		else if (busy && stepsLeft != '0)
			operand <= shiftOne(operand);
	end

	assign shlDone = busy && (stepsLeft == '0);
	assign shlResult = operand;

	//////////////////////////////
	// Checks

	startWhileBusy: assert property (@(posedge clk) disable iff (reset)
		shlStart |-> !busy)
		else $error("lShl: start while a shift is in progress");

	doneOneCycle: assert property (@(posedge clk) disable iff (reset)
		shlDone |=> !shlDone)
		else $error("lShl: done held longer than one cycle");

endmodule

/* run.sh */
#!/bin/sh
# Build the convolution testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module convTb -f all.f -o convTbSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/convTbSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* scratchRam.sv */
module scratchRam
	(
	input  logic             clk,
	input  convPkg::memReqT  engineReq,
	output convPkg::memWordT engineReadData,
	input  convPkg::hostReqT host,
	output convPkg::memWordT hostReadData
	);
	import convPkg::*;

	memWordT mem [MEM_DEPTH];

	// Both ports in one process, reads return the old word on a same-cycle write
	always_ff @(posedge clk)
	begin
		if (engineReq.writeEn)
			mem[engineReq.addr] <= engineReq.data;
		if (host.writeEn)
			mem[host.addr] <= host.data;
		engineReadData <= mem[engineReq.addr];
		hostReadData <= mem[host.addr];
	end

	// Host and engine must never write the same word together
	writeCollision: assert property (@(posedge clk)
		(engineReq.writeEn && host.writeEn) |-> (engineReq.addr != host.addr))
		else $error("scratchRam: host and engine write address %h together", host.addr);

endmodule
